/* Makefile */
VERILATOR  ?= verilator
TOP        ?= exeStage_tb
RTL_TOP    ?= exeStage
FILELIST   ?= exeStage.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   ?= Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* alu.sv */
module alu import rvIsaPkg::*; (
	input  aluFn_t      aluFn,
	input  logic [31:0] operandA,
	input  logic [31:0] operandB,
	input  logic        btype,
	input  logic        bneq,
	output logic [31:0] result,
	output logic        btaken
);

	logic [4:0] shamt;
	logic       isEq;
	logic       isLt;
	logic       isLtu;
	logic       cmp;

	assign shamt = operandB[4:0];
	assign isEq  = (operandA == operandB);
	assign isLt  = ($signed(operandA) < $signed(operandB));
	assign isLtu = (operandA < operandB);

	always_comb
	begin
		case (aluFn)
			aluAdd:   result = operandA + operandB;
			aluSub:   result = operandA - operandB;
			aluSll:   result = operandA << shamt;
			aluSlt:   result = {31'b0, isLt};
			aluSltu:  result = {31'b0, isLtu};
			aluXor:   result = operandA ^ operandB;
			aluSrl:   result = operandA >> shamt;
			aluSra:   result = $unsigned($signed(operandA) >>> shamt);
			aluOr:    result = operandA | operandB;
			aluAnd:   result = operandA & operandB;
			aluPassB: result = operandB;
			default:  result = '0;
		endcase
	end

	// slt picks blt/bge, sltu picks bltu/bgeu, anything else beq/bne
	always_comb
	begin
		case (aluFn)
			aluSlt:  cmp = isLt;
			aluSltu: cmp = isLtu;
			default: cmp = isEq;
		endcase
	end

	assign btaken = btype & (cmp ^ bneq);

	// a branch packet carries one of the three compare encodings
	always_comb
	begin
		if (btype)
			assert (aluFn inside {aluSub, aluSlt, aluSltu})
				else $error("alu: branch packet without a compare aluFn");
	end

endmodule

/* branchUnit.sv */
module branchUnit import exePipePkg::*; (
	input  logic [31:0]  pc,
	input  logic [31:0]  operandA,
	input  logic [31:0]  operandB,  // I immediate for jalr
	input  logic [31:0]  bImm,
	input  logic [31:0]  jImm,
	input  logic         j,
	input  logic         jr,
	input  logic         btaken,
	output exeRedirect_t redirect
);

	logic [31:0] jrSum;

	assign jrSum = operandA + operandB;

	always_comb
	begin
		if (jr)
			redirect.target = {jrSum[31:1], 1'b0}; // jalr clears bit 0
		else if (j)
			redirect.target = pc + jImm;
		else
			redirect.target = pc + bImm;
		redirect.taken = btaken | j | jr;
	end

	// decode never marks a packet as both jal and jalr
	always_comb
	begin
		assert (!(j && jr))
			else $error("branchUnit: j and jr both set");
	end

endmodule

/* dataMem.sv */
module dataMem import rvIsaPkg::*, exePipePkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  memOp_t      memOp,
	input  logic [31:0] base,
	input  logic [31:0] storeData,  // store data, or I offset for loads
	input  logic [31:0] sImm,
	output logic [31:0] loadData,
	output logic        addrMisaligned
);

	logic [31:0] mem [dmemWords];

	logic        isStore;
	logic        misNow;
	logic        wrEn;
	logic [31:0] addr;
	logic [3:0]  byteEn;
	logic [31:0] wrData;
	logic [$clog2(dmemWords)-1:0] wrIdx;
	logic [$clog2(dmemWords)-1:0] rdIdx;

	memOp_t      op5;
	logic [31:0] addr5;
	logic [31:0] oldWord5;  // word at the access index before the s5 edge
	memOp_t      op6;
	logic [1:0]  off6;
	logic [31:0] rdWord6;
	logic [31:0] shifted;

	assign isStore = (memOp == memSb) || (memOp == memSh) || (memOp == memSw);
	assign addr    = isStore ? base + sImm : base + storeData;
	assign wrIdx   = addr[$clog2(dmemWords)+1:2];
	assign rdIdx   = addr5[$clog2(dmemWords)+1:2];

	always_comb
	begin
		case (memOp)
			memLh, memLhu, memSh: misNow = addr[0];
			memLw, memSw:         misNow = |addr[1:0];
			default:              misNow = 1'b0;
		endcase
	end

	assign wrEn = isStore && !misNow; // misaligned store is dropped

	always_comb
	begin
		case (memOp)
			memSb:
			begin
				byteEn = 4'b0001 << addr[1:0];
				wrData = {4{storeData[7:0]}};
			end
			memSh:
			begin
				byteEn = 4'b0011 << addr[1:0];
				wrData = {2{storeData[15:0]}};
			end
			default:
			begin
				byteEn = 4'b1111;
				wrData = storeData;
			end
		endcase
	end

	// write at the s5 edge, straight from the issue fields
	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (byteEn[i])
					mem[wrIdx][8*i +: 8] <= wrData[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			op5            <= memNone;
			addr5          <= '0;
			oldWord5       <= '0;
			addrMisaligned <= 1'b0;
			op6            <= memNone;
			off6           <= '0;
			rdWord6        <= '0;
		end
		else
		begin
			op5            <= memOp;
			addr5          <= addr;
			oldWord5       <= mem[wrIdx];
			addrMisaligned <= misNow;
			op6            <= op5;
			off6           <= addr5[1:0];
			rdWord6        <= mem[rdIdx]; // sync read, sees a store from the previous edge
		end
	end

	assign shifted = rdWord6 >> {off6, 3'b000};

	always_comb
	begin
		case (op6)
			memLb:   loadData = {{24{shifted[7]}}, shifted[7:0]};
			memLbu:  loadData = {24'b0, shifted[7:0]};
			memLh:   loadData = {{16{shifted[15]}}, shifted[15:0]};
			memLhu:  loadData = {16'b0, shifted[15:0]};
			memLw:   loadData = rdWord6;
			default: loadData = '0;
		endcase
	end

	// a misaligned access leaves its word as it was before the s5 edge
	assert property (@(posedge clk) disable iff (!nrst)
		addrMisaligned |-> mem[rdIdx] === oldWord5)
		else $error("dataMem: store written at a misaligned address");

endmodule

/* exePipePkg.sv */
package exePipePkg;

	import rvIsaPkg::*;

	localparam int unsigned dmemWords = 256;    // data memory depth in 32-bit words
	localparam logic [31:0] linkOffset = 32'd4; // return address = pc + 4

	// decoded packet as it leaves issue, operands already read
	typedef struct packed {
		logic [31:0] opA;
		logic [31:0] opB;   // rs2 or I immediate
		logic [31:0] pc;
		logic [31:0] bImm;
		logic [31:0] jImm;
		logic [31:0] uImm;
		logic [31:0] sImm;
		logic [4:0]  rd;
		wbSel_t      wbSel;
		aluFn_t      aluFn;
		memOp_t      memOp;
		mulDivOp_t   mulDivOp;
		logic        we;
		logic        btype; // conditional branch
		logic        bneq;  // invert the compare
		logic        j;     // jal
		logic        jr;    // jalr
	} exeIssue_t;

	// write-back word
	typedef struct packed {
		logic [31:0] wbData;
		logic [4:0]  rd;
		logic        we;
	} exeResult_t;

	// fetch redirect
	typedef struct packed {
		logic        taken;
		logic [31:0] target;
	} exeRedirect_t;

endpackage

/* exeStage.f */
rvIsaPkg.sv
exePipePkg.sv
alu.sv
branchUnit.sv
dataMem.sv
mulDiv.sv
exeStage.sv
exeStage_tb.sv

/* exeStage.sv */
module exeStage import rvIsaPkg::*, exePipePkg::*; (
	input  logic         clk,
	input  logic         nrst,
	input  exeIssue_t    issue,
	output exeResult_t   result,
	output exeRedirect_t redirect,
	output logic         addrMisaligned
);

	// what survives into the write-back cycle
	typedef struct packed {
		logic [31:0] aluRes;
		logic [31:0] mulDivRes;
		logic [31:0] uImm;
		logic [31:0] uSum;  // auipc
		logic [31:0] pc;
		logic [4:0]  rd;
		wbSel_t      wbSel;
		logic        we;
	} exeS6_t;

	exeIssue_t   s5;
	exeS6_t      s6;

	logic [31:0] aluRes5;
	logic        btaken5;
	logic [31:0] mulDivRes5;
	logic [31:0] loadData6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			s5 <= '0;
		else
			s5 <= issue;
	end

	alu alu_i (
		.aluFn    (s5.aluFn),
		.operandA (s5.opA),
		.operandB (s5.opB),
		.btype    (s5.btype),
		.bneq     (s5.bneq),
		.result   (aluRes5),
		.btaken   (btaken5)
	);

	branchUnit branchUnit_i (
		.pc       (s5.pc),
		.operandA (s5.opA),
		.operandB (s5.opB),
		.bImm     (s5.bImm),
		.jImm     (s5.jImm),
		.j        (s5.j),
		.jr       (s5.jr),
		.btaken   (btaken5),
		.redirect (redirect)
	);

	mulDiv mulDiv_i (
		.a        (s5.opA),
		.b        (s5.opB),
		.mulDivOp (s5.mulDivOp),
		.res      (mulDivRes5)
	);

	// memory sees the packet at issue, its own registers track s5/s6
	dataMem dataMem_i (
		.clk            (clk),
		.nrst           (nrst),
		.memOp          (issue.memOp),
		.base           (issue.opA),
		.storeData      (issue.opB),
		.sImm           (issue.sImm),
		.loadData       (loadData6),
		.addrMisaligned (addrMisaligned)
	);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			s6 <= '0;
		else
		begin
			s6.aluRes    <= aluRes5;
			s6.mulDivRes <= mulDivRes5;
			s6.uImm      <= s5.uImm;
			s6.uSum      <= s5.uImm + s5.pc;
			s6.pc        <= s5.pc;
			s6.rd        <= s5.rd;
			s6.wbSel     <= s5.wbSel;
			s6.we        <= s5.we;
		end
	end

	always_comb
	begin
		case (s6.wbSel)
			wbAlu:    result.wbData = s6.aluRes;
			wbLink:   result.wbData = s6.pc + linkOffset;
			wbMulDiv: result.wbData = s6.mulDivRes;
			wbUpper:  result.wbData = s6.uImm;
			wbMem:    result.wbData = loadData6;
			wbAuipc:  result.wbData = s6.uSum;
			default:  result.wbData = '0;
		endcase
		result.rd = s6.rd;
		result.we = s6.we;
	end

	// a write issued two cycles back must carry a defined source
	assert property (@(posedge clk) disable iff (!nrst)
		$past(issue.we, 2) && result.we |-> s6.wbSel inside {[wbAlu:wbAuipc]})
		else $error("exeStage: undefined wbSel on a register write");

endmodule

/* exeStage_tb.sv */
module exeStage_tb import rvIsaPkg::*, exePipePkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int aluPerFn  = 20;
	localparam int mdPerOp   = 16;
	localparam int nBranch   = 100;
	localparam int nJump     = 10;
	localparam int nUpper    = 20;
	localparam int fillWords = 64;  // memory region under test
	localparam int nMemOps   = 120;
	localparam int nMisalign = 20;
	localparam int totalPackets = 11 * aluPerFn + 8 * (mdPerOp + 2) + nBranch + 2 * nJump
		+ 2 * nUpper + fillWords + nMemOps + 3 * nMisalign;
	localparam int cycleLimit = 2 * totalPackets + 500;

	// what one packet should produce
	typedef struct packed {
		exeResult_t   res;
		exeRedirect_t redir;
		logic         mis;
	} expEntry_t;

	logic         clk;
	logic         nrst;
	exeIssue_t    issue;
	exeResult_t   result;
	exeRedirect_t redirect;
	logic         addrMisaligned;

	expEntry_t    pipeQ[$];  // [0] in s5, [1] in s6
	expEntry_t    expS5;
	expEntry_t    expS6;
	logic [7:0]   memBytes [dmemWords * 4];
	int           errCount = 0;
	int           errMark = 0;
	int           testsPassed = 0;
	int           testsFailed = 0;
	int           cycles = 0;
	int           storeIdx;
	int           storeLen;

	exeStage exeStage_i (
		.clk            (clk),
		.nrst           (nrst),
		.issue          (issue),
		.result         (result),
		.redirect       (redirect),
		.addrMisaligned (addrMisaligned)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout: run reached %0d cycles without finishing", cycleLimit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic isStoreOp(memOp_t op);
		return (op == memSb) || (op == memSh) || (op == memSw);
	endfunction

	function automatic logic [31:0] aluRef(aluFn_t fn, logic [31:0] a, logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (fn)
			aluAdd:   return a + b;
			aluSub:   return a - b;
			aluSll:   return a << sh;
			aluSlt:   return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)}; // sign decides first
			aluSltu:  return {31'b0, a < b};
			aluXor:   return a ^ b;
			aluSrl:   return a >> sh;
			aluSra:   return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
			aluOr:    return a | b;
			aluAnd:   return a & b;
			aluPassB: return b;
			default:  return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] mulDivRef(mulDivOp_t op, logic [31:0] a, logic [31:0] b);
		logic [63:0] sa;
		logic [63:0] sb;
		logic [63:0] ua;
		logic [63:0] ub;
		logic [63:0] prod;
		logic [31:0] magA;
		logic [31:0] magB;
		logic [31:0] q;
		logic [31:0] r;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'b0, a};
		ub = {32'b0, b};
		magA = a[31] ? -a : a;
		magB = b[31] ? -b : b;
		q = '1;
		r = a;
		// magnitudes, then signs; overflow falls out as q = a, r = 0
		if (b != 0)
		begin
			q = (a[31] ^ b[31]) ? -(magA / magB) : magA / magB;
			r = a[31] ? -(magA % magB) : magA % magB;
		end
		case (op)
			mdMulh:   prod = sa * sb;
			mdMulhsu: prod = sa * ub;
			default:  prod = ua * ub;
		endcase
		case (op)
			mdMul:                     return prod[31:0];
			mdMulh, mdMulhsu, mdMulhu: return prod[63:32];
			mdDiv:                     return q;
			mdDivu:                    return (b == 0) ? '1 : a / b;
			mdRem:                     return r;
			default:                   return (b == 0) ? a : a % b;
		endcase
	endfunction

	function automatic logic [31:0] loadRef(memOp_t op, logic [31:0] addr);
		int i;
		i = int'(addr & 32'(dmemWords * 4 - 1));
		case (op)
			memLb:   return {{24{memBytes[i][7]}}, memBytes[i]};
			memLbu:  return {24'b0, memBytes[i]};
			memLh:   return {{16{memBytes[i + 1][7]}}, memBytes[i + 1], memBytes[i]};
			memLhu:  return {16'b0, memBytes[i + 1], memBytes[i]};
			memLw:   return {memBytes[i + 3], memBytes[i + 2], memBytes[i + 1], memBytes[i]};
			default: return 32'd0;
		endcase
	endfunction

	function automatic expEntry_t predict(exeIssue_t p);
		expEntry_t   e;
		logic [31:0] addr;
		logic        cmp;
		addr = isStoreOp(p.memOp) ? p.opA + p.sImm : p.opA + p.opB;
		case (p.aluFn)
			aluSlt:  cmp = $signed(p.opA) < $signed(p.opB);
			aluSltu: cmp = p.opA < p.opB;
			default: cmp = p.opA == p.opB;
		endcase
		e.redir.taken = (p.btype && (cmp != p.bneq)) || p.j || p.jr;
		e.redir.target = p.jr ? (p.opA + p.opB) & ~32'd1 : p.pc + (p.j ? p.jImm : p.bImm);
		case (p.memOp)
			memLh, memLhu, memSh: e.mis = addr[0];
			memLw, memSw:         e.mis = addr[1:0] != 2'b00;
			default:              e.mis = 1'b0;
		endcase
		e.res.rd = p.rd;
		e.res.we = p.we;
		case (p.wbSel)
			wbAlu:    e.res.wbData = aluRef(p.aluFn, p.opA, p.opB);
			wbLink:   e.res.wbData = p.pc + linkOffset;
			wbMulDiv: e.res.wbData = mulDivRef(p.mulDivOp, p.opA, p.opB);
			wbUpper:  e.res.wbData = p.uImm;
			wbMem:    e.res.wbData = loadRef(p.memOp, addr);
			wbAuipc:  e.res.wbData = p.uImm + p.pc;
			default:  e.res.wbData = 32'd0;
		endcase
		return e;
	endfunction

	// expected values move with the packets
	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pipeQ.delete();
			pipeQ.push_back(expEntry_t'(0));
			pipeQ.push_back(expEntry_t'(0));
		end
		else
		begin
			pipeQ.push_front(predict(issue));
			pipeQ.delete(2);
			if (isStoreOp(issue.memOp) && !pipeQ[0].mis)
			begin
				storeIdx = int'((issue.opA + issue.sImm) & 32'(dmemWords * 4 - 1));
				storeLen = (issue.memOp == memSb) ? 1 : (issue.memOp == memSh) ? 2 : 4;
				for (int k = 0; k < storeLen; k++)
					memBytes[storeIdx + k] = issue.opB[8 * k +: 8];
			end
		end
		expS5 = pipeQ[0];
		expS6 = pipeQ[1];
	end

	assert property (@(negedge clk) !nrst |-> !result.we && !redirect.taken && !addrMisaligned)
		else
		begin
			errCount++;
			$display("FAILED %0t reset outputs exp 0 got we=%b taken=%b mis=%b", $time,
				result.we, redirect.taken, addrMisaligned);
		end

	assert property (@(negedge clk) disable iff (!nrst) result === expS6.res)
		else
		begin
			errCount++;
			$display("FAILED %0t result exp %h got %h", $time, expS6.res, result);
		end

	assert property (@(negedge clk) disable iff (!nrst) redirect === expS5.redir)
		else
		begin
			errCount++;
			$display("FAILED %0t redirect exp %h got %h", $time, expS5.redir, redirect);
		end

	assert property (@(negedge clk) disable iff (!nrst) addrMisaligned === expS5.mis)
		else
		begin
			errCount++;
			$display("FAILED %0t addrMisaligned exp %b got %b", $time, expS5.mis,
				addrMisaligned);
		end

	task automatic sendPacket(input exeIssue_t p);
		@(negedge clk);
		issue = p;
	endtask

	function automatic exeIssue_t randomBase();
		exeIssue_t p;
		p = '0;
		p.opA = $urandom;
		p.opB = $urandom;
		p.pc = $urandom & 32'hffff_fffc;
		p.bImm = $urandom;
		p.jImm = $urandom;
		p.uImm = $urandom;
		p.sImm = $urandom;
		p.rd = 5'($urandom_range(1, 31));
		p.aluFn = aluFn_t'(4'($urandom_range(0, 10)));
		p.mulDivOp = mulDivOp_t'(3'($urandom_range(0, 7)));
		p.wbSel = wbAlu;
		p.memOp = memNone;
		p.we = 1'b1;
		return p;
	endfunction

	function automatic logic [31:0] alignedAddr(memOp_t op);
		logic [31:0] a;
		a = $urandom_range(0, fillWords * 4 - 1);
		case (op)
			memSh, memLh, memLhu: a[0] = 1'b0;
			memSw, memLw:         a[1:0] = 2'b00;
			default:              ;
		endcase
		return a;
	endfunction

	task automatic memPacket(input memOp_t op, input logic [31:0] addr, input logic [31:0] data,
		input wbSel_t sel);
		exeIssue_t p;
		p = randomBase();
		p.memOp = op;
		p.opA = $urandom_range(0, 4095); // base, offset makes up the rest
		p.aluFn = aluAdd;
		p.wbSel = sel;
		if (isStoreOp(op))
		begin
			p.opB = data;
			p.sImm = addr - p.opA;
			p.we = 1'b0;
		end
		else
			p.opB = addr - p.opA;
		sendPacket(p);
	endtask

	// flush two bubbles so the last packet is checked
	task automatic finishTest(input string name);
		exeIssue_t bubble;
		bubble = '0;
		sendPacket(bubble);
		sendPacket(bubble);
		@(posedge clk);
		if (errCount == errMark)
			testsPassed++;
		else
			testsFailed++;
		$display("test %s done, %0d errors", name, errCount - errMark);
		errMark = errCount;
	endtask

	initial
	begin
		exeIssue_t   p;
		aluFn_t      cmpFns [3];
		memOp_t      memOps [8];
		memOp_t      op;
		logic [31:0] wa;
		void'($urandom(32'h93cb_a96d));
		cmpFns = '{aluSub, aluSlt, aluSltu};
		memOps = '{memSb, memSh, memSw, memLb, memLh, memLw, memLbu, memLhu};
		nrst = 1'b0;
		issue = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		finishTest("reset");

		for (int f = 0; f <= 10; f++)
		begin
			for (int n = 0; n < aluPerFn; n++)
			begin
				p = randomBase();
				p.aluFn = aluFn_t'(4'(f));
				sendPacket(p);
			end
		end
		finishTest("alu");

		for (int o = 0; o < 8; o++)
		begin
			for (int n = 0; n < mdPerOp + 2; n++)
			begin
				p = randomBase();
				p.mulDivOp = mulDivOp_t'(3'(o));
				p.wbSel = wbMulDiv;
				if (n == mdPerOp)
					p.opB = '0;  // divide by zero
				else if (n == mdPerOp + 1)
				begin
					p.opA = 32'h8000_0000;  // signed overflow
					p.opB = 32'hffff_ffff;
				end
				sendPacket(p);
			end
		end
		finishTest("mulDiv");

		for (int n = 0; n < nBranch; n++)
		begin
			p = randomBase();
			p.btype = 1'b1;
			p.bneq = 1'($urandom_range(0, 1));
			p.aluFn = cmpFns[$urandom_range(0, 2)];
			p.we = 1'b0;
			if ($urandom_range(0, 1) == 1)
				p.opB = p.opA;  // half the branches compare equal
			sendPacket(p);
		end
		for (int n = 0; n < 2 * nJump; n++)
		begin
			p = randomBase();
			p.j = (n < nJump);
			p.jr = (n >= nJump);
			p.wbSel = wbLink;
			sendPacket(p);
		end
		finishTest("control");

		for (int n = 0; n < 2 * nUpper; n++)
		begin
			p = randomBase();
			p.uImm = p.uImm & 32'hffff_f000;
			p.wbSel = (n < nUpper) ? wbUpper : wbAuipc;
			sendPacket(p);
		end
		finishTest("upper");

		for (int w = 0; w < fillWords; w++)
			memPacket(memSw, 32'(4 * w), 32'(4 * w) * 32'h9e37_79b9 ^ 32'h0f1e_2d3c, wbAlu);
		for (int n = 0; n < nMemOps; n++)
		begin
			op = memOps[$urandom_range(0, 7)];
			memPacket(op, alignedAddr(op), $urandom, wbMem);
		end
		for (int n = 0; n < nMisalign; n++)
		begin
			wa = alignedAddr(memLw);
			if (n % 2 == 0)
				memPacket(memSh, wa + 32'(1 + 2 * $urandom_range(0, 1)), $urandom, wbAlu);
			else
				memPacket(memSw, wa + 32'($urandom_range(1, 3)), $urandom, wbAlu);
			memPacket(memLw, wa, 0, wbMem);  // word must be unchanged
			memPacket(memLh, wa + 32'd1, 0, wbAlu);
		end
		finishTest("memory");

		$display("%0d tests passed, %0d tests failed, %0d check errors", testsPassed,
			testsFailed, errCount);
		if (testsFailed == 0 && errCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* mulDiv.sv */
module mulDiv import rvIsaPkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  mulDivOp_t   mulDivOp,
	output logic [31:0] res
);

	logic signed [63:0] prodSs;
	logic signed [63:0] prodSu;
	logic        [63:0] prodUu;
	logic               divZero;
	logic               overflow;
	logic        [31:0] quot;
	logic        [31:0] quotU;
	logic        [31:0] remS;
	logic        [31:0] remU;

	assign prodSs = $signed(a) * $signed(b);
	assign prodSu = $signed({{32{a[31]}}, a}) * $signed({32'b0, b}); // rs2 as unsigned
	assign prodUu = {32'b0, a} * {32'b0, b};

	assign divZero  = (b == '0);
	assign overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);

	// RISC-V results for the corner cases, nothing traps
	assign quot  = divZero ? '1 : overflow ? a : $unsigned($signed(a) / $signed(b));
	assign remS  = divZero ? a : overflow ? '0 : $unsigned($signed(a) % $signed(b));
	assign quotU = divZero ? '1 : a / b;
	assign remU  = divZero ? a : a % b;

	always_comb
	begin
		case (mulDivOp)
			mdMul:    res = prodUu[31:0];
			mdMulh:   res = prodSs[63:32];
			mdMulhsu: res = prodSu[63:32];
			mdMulhu:  res = prodUu[63:32];
			mdDiv:    res = quot;
			mdDivu:   res = quotU;
			mdRem:    res = remS;
			default:  res = remU;
		endcase
	end

endmodule

/* rvIsaPkg.sv */
package rvIsaPkg;

	// ALU function, also selects the compare used by branches
	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,  // beq / bne compare
		aluSll   = 4'd2,
		aluSlt   = 4'd3,  // blt / bge compare
		aluSltu  = 4'd4,  // bltu / bgeu compare
		aluXor   = 4'd5,
		aluSrl   = 4'd6,
		aluSra   = 4'd7,
		aluOr    = 4'd8,
		aluAnd   = 4'd9,
		aluPassB = 4'd10
	} aluFn_t;

	// load and store kinds
	typedef enum logic [3:0] {
		memNone = 4'd0,
		memLb   = 4'd1,
		memLh   = 4'd2,
		memLw   = 4'd3,
		memLbu  = 4'd4,
		memLhu  = 4'd5,
		memSb   = 4'd6,
		memSh   = 4'd7,
		memSw   = 4'd8
	} memOp_t;

	// RV32M ops, same order as funct3
	typedef enum logic [2:0] {
		mdMul    = 3'd0,
		mdMulh   = 3'd1,
		mdMulhsu = 3'd2,
		mdMulhu  = 3'd3,
		mdDiv    = 3'd4,
		mdDivu   = 3'd5,
		mdRem    = 3'd6,
		mdRemu   = 3'd7
	} mulDivOp_t;

	// write-back source, codes 6 and 7 unused
	typedef enum logic [2:0] {
		wbAlu    = 3'd0,
		wbLink   = 3'd1,
		wbMulDiv = 3'd2,
		wbUpper  = 3'd3,  // lui
		wbMem    = 3'd4,
		wbAuipc  = 3'd5
	} wbSel_t;

endpackage
